/* rtl/az_pkg.sv */
//////////////////////////////
// shared types for the autozero modulator.
// phase enum, mux union, timing, status and sample structs.
//////////////////////////////

package az_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  // phase length in clocks.
  localparam int AZ_COUNT_W = 24;

  // az mux word, as driven to the pins.
  localparam int AZ_MUX_W = 4;

  // running cycle number carried with each sample event.
  localparam int AZ_INDEX_W = 16;

  //////////////////////////////
  // sequencer phases
  //////////////////////////////

  // idle after reset, boot before the first cycle, park after run drops.
  typedef enum logic [2:0] {
    IDLE,
    BOOT,
    PRECHARGE,
    SIGNAL,
    PROTECT,
    ZERO,
    PARK
  } az_phase_e;

  // precharge switch levels.
  localparam logic SW_PC_BOOT   = 1'b0;
  localparam logic SW_PC_SIGNAL = 1'b1;

  //////////////////////////////
  // az mux word
  //////////////////////////////

  // field view of the mux word.
  // en is the top bit and sel picks the mux input.
  typedef struct packed {
    logic       en;
    logic [2:0] sel;
  } az_mux_fields_t;

  // the same 4 bits seen as pin levels or as decoded fields.
  typedef union packed {
    logic [AZ_MUX_W-1:0] raw;
    az_mux_fields_t      fields;
  } az_mux_u;

  // precharge output is en with sel 0.
  localparam az_mux_u AZ_MUX_PC_OUT = 4'b1000;
  // everything open.
  localparam az_mux_u AZ_MUX_OFF    = 4'b0000;

  //////////////////////////////
  // bundles between blocks
  //////////////////////////////

  // phase lengths and the low mux value for one cycle.
  typedef struct packed {
    logic [AZ_COUNT_W-1:0] precharge_n;
    logic [AZ_COUNT_W-1:0] sample_n;
    az_mux_u               lo_val;
  } az_timing_t;

  // phase_end is high on the last clock of a timed phase.
  typedef struct packed {
    az_phase_e phase;
    logic      phase_end;
  } az_status_t;

  // kind is 1 for a signal sample and 0 for a zero sample.
  typedef struct packed {
    logic                  kind;
    logic [AZ_INDEX_W-1:0] cycle_index;
  } az_sample_t;

endpackage

/* rtl/az_timing_regs.sv */
//////////////////////////////
// timing register bank.
// shadow copy for loads, active copy applied at cycle start.
//////////////////////////////

`timescale 1ns/1ns

module az_timing_regs #(
  parameter logic [az_pkg::AZ_COUNT_W-1:0] PRECHARGE_N_RESET = 24'd10000,
  parameter logic [az_pkg::AZ_COUNT_W-1:0] SAMPLE_N_RESET    = 24'd400000
) (
  input  logic               clk,
  input  logic               reset,
  // new setting from outside.
  input  logic               load,
  input  az_pkg::az_timing_t timing_in,
  // cycle boundary from the sequencer.
  input  logic               cycle_start,
  // setting in force for the running cycle.
  output az_pkg::az_timing_t timing
);

  // values after reset, mux parked open.
  localparam az_pkg::az_timing_t TIMING_RESET = '{
    precharge_n: PRECHARGE_N_RESET,
    sample_n:    SAMPLE_N_RESET,
    lo_val:      az_pkg::AZ_MUX_OFF
  };

  az_pkg::az_timing_t shadow;
  az_pkg::az_timing_t active;

  // a zero length would never end a phase.
  // it runs as a one clock phase instead.
  function automatic logic [az_pkg::AZ_COUNT_W-1:0] clamp_n(
    input logic [az_pkg::AZ_COUNT_W-1:0] n
  );
    clamp_n = (n == '0) ? az_pkg::AZ_COUNT_W'(1) : n;
  endfunction

  //////////////////////////////
  // shadow register
  //////////////////////////////

  // a load may land anywhere in a cycle.
  always_ff @(posedge clk or posedge reset)
    if (reset)
    begin
      shadow <= TIMING_RESET;
    end
    else if (load)
    begin
      shadow.precharge_n <= clamp_n(timing_in.precharge_n);
      shadow.sample_n    <= clamp_n(timing_in.sample_n);
      shadow.lo_val      <= timing_in.lo_val;
    end

  //////////////////////////////
  // active register
  //////////////////////////////

  // only moves on the cycle boundary.
  // signal and zero of one cycle always see the same sample_n.
  always_ff @(posedge clk or posedge reset)
    if (reset)
      active <= TIMING_RESET;
    else if (cycle_start)
      active <= shadow;

  assign timing = active;

  // the sequencer down counter relies on lengths of at least one.
  a_active_nonzero: assert property (
    @(posedge clk) disable iff (reset)
    (active.precharge_n != '0) && (active.sample_n != '0)
  );

endmodule

/* rtl/az_sequencer.sv */
//////////////////////////////
// autozero phase FSM.
// down counter, precharge switch and az mux control.
//////////////////////////////

`timescale 1ns/1ns

module az_sequencer (
  input  logic               clk,
  input  logic               reset,
  // level, cycles keep running while high.
  input  logic               run,
  // active timing, stable over a cycle.
  input  az_pkg::az_timing_t timing,
  // pulse on the clock that enters boot or precharge.
  output logic               cycle_start,
  output az_pkg::az_status_t status,
  output logic               sw_pc_ctl,
  output az_pkg::az_mux_u    azmux
);

  az_pkg::az_phase_e               phase;
  az_pkg::az_phase_e               phase_nxt;
  logic [az_pkg::AZ_COUNT_W-1:0]   cnt;
  logic [az_pkg::AZ_COUNT_W-1:0]   len;
  logic                            timed;
  logic                            phase_end;
  logic                            advance;
  az_pkg::az_mux_u                 azmux_nxt;

  //////////////////////////////
  // phase length and end
  //////////////////////////////

  // settle phases use the precharge length, samples use sample_n.
  always_comb
    case (phase)
      az_pkg::BOOT, az_pkg::PRECHARGE, az_pkg::PROTECT:
        len = timing.precharge_n;
      az_pkg::SIGNAL, az_pkg::ZERO:
        len = timing.sample_n;
      default:
        len = az_pkg::AZ_COUNT_W'(1);
    endcase

  // idle and park wait on run, not on the counter.
  assign timed = (phase != az_pkg::IDLE) && (phase != az_pkg::PARK);

  // cnt is zero on the first clock of a phase and is loaded there.
  // after that it counts down to 1 on the last clock.
  assign phase_end = timed && ((cnt == '0) ? (len == az_pkg::AZ_COUNT_W'(1))
                                           : (cnt == az_pkg::AZ_COUNT_W'(1)));

  //////////////////////////////
  // next phase
  //////////////////////////////

  always_comb
  begin
    phase_nxt = phase;
    case (phase)
      az_pkg::IDLE, az_pkg::PARK:
        if (run)
          phase_nxt = az_pkg::BOOT;
      az_pkg::BOOT:
        if (phase_end)
          phase_nxt = az_pkg::PRECHARGE;
      az_pkg::PRECHARGE:
        if (phase_end)
          phase_nxt = az_pkg::SIGNAL;
      az_pkg::SIGNAL:
        if (phase_end)
          phase_nxt = az_pkg::PROTECT;
      az_pkg::PROTECT:
        if (phase_end)
          phase_nxt = az_pkg::ZERO;
      az_pkg::ZERO:
        if (phase_end)
          phase_nxt = run ? az_pkg::PRECHARGE : az_pkg::PARK;
      default:
        phase_nxt = az_pkg::IDLE;
    endcase
  end

  assign advance     = (phase_nxt != phase);
  // the timing bank swaps on this edge, so the new phase reads the new values.
  assign cycle_start = advance && ((phase_nxt == az_pkg::BOOT) ||
                                   (phase_nxt == az_pkg::PRECHARGE));

  // mux for the phase being entered.
  // pc out is held from precharge through protect.
  always_comb
    case (phase_nxt)
      az_pkg::PRECHARGE, az_pkg::SIGNAL, az_pkg::PROTECT:
        azmux_nxt = az_pkg::AZ_MUX_PC_OUT;
      az_pkg::ZERO:
        azmux_nxt = timing.lo_val;
      default:
        azmux_nxt = az_pkg::AZ_MUX_OFF;
    endcase

  //////////////////////////////
  // state, counter and switches
  //////////////////////////////

  always_ff @(posedge clk or posedge reset)
    if (reset)
    begin
      phase     <= az_pkg::IDLE;
      cnt       <= '0;
      sw_pc_ctl <= az_pkg::SW_PC_BOOT;
      azmux     <= az_pkg::AZ_MUX_OFF;
    end
    else
    begin
      phase <= phase_nxt;
      if (advance)
        cnt <= '0;
      else if (cnt == '0)
        cnt <= len - az_pkg::AZ_COUNT_W'(1);
      else
        cnt <= cnt - az_pkg::AZ_COUNT_W'(1);
      // the signal is only exposed inside the precharge window.
      sw_pc_ctl <= (phase_nxt == az_pkg::SIGNAL) ? az_pkg::SW_PC_SIGNAL
                                                 : az_pkg::SW_PC_BOOT;
      azmux     <= azmux_nxt;
    end

  assign status.phase     = phase;
  assign status.phase_end = phase_end;

  // charge injection from the az mux must never reach the exposed signal.
  a_mux_quiet_in_signal: assert property (
    @(posedge clk) disable iff (reset)
    ((sw_pc_ctl == az_pkg::SW_PC_SIGNAL) || ($past(sw_pc_ctl) == az_pkg::SW_PC_SIGNAL))
      |-> $stable(azmux.raw)
  );

  a_signal_only_in_signal: assert property (
    @(posedge clk) disable iff (reset)
    (sw_pc_ctl == az_pkg::SW_PC_SIGNAL) |-> (phase == az_pkg::SIGNAL)
  );

  // zero sample must read a low reference, never the precharge output.
  a_zero_not_pc_out: assert property (
    @(posedge clk) disable iff (reset)
    (phase == az_pkg::ZERO) |-> !(azmux.fields.en && (azmux.fields.sel == 3'd0))
  );

endmodule

/* rtl/az_sample_marker.sv */
//////////////////////////////
// sample end events for the ADC.
// cycle index, LED and monitor byte.
//////////////////////////////

`timescale 1ns/1ns

module az_sample_marker (
  input  logic               clk,
  input  logic               reset,
  input  az_pkg::az_status_t status,
  input  az_pkg::az_mux_u    azmux,
  // one clock after the last clock of a sample window.
  output logic               sample_done,
  output az_pkg::az_sample_t sample,
  output logic               led0,
  output logic [7:0]         monitor
);

  logic                          in_signal;
  logic                          in_zero;
  logic [az_pkg::AZ_INDEX_W-1:0] cycle_cnt;

  assign in_signal = (status.phase == az_pkg::SIGNAL);
  assign in_zero   = (status.phase == az_pkg::ZERO);

  //////////////////////////////
  // sample events
  //////////////////////////////

  // cycle_cnt survives park, only reset clears it.
  always_ff @(posedge clk or posedge reset)
    if (reset)
    begin
      sample_done <= 1'b0;
      sample      <= '0;
      cycle_cnt   <= '0;
    end
    else
    begin
      sample_done <= status.phase_end && (in_signal || in_zero);
      if (status.phase_end && (in_signal || in_zero))
      begin
        sample.kind        <= in_signal;
        sample.cycle_index <= cycle_cnt;
      end
      // the zero sample closes a cycle.
      if (status.phase_end && in_zero)
        cycle_cnt <= cycle_cnt + 1'b1;
    end

  //////////////////////////////
  // led and monitor
  //////////////////////////////

  // led lit from signal until zero starts.
  // monitor bit 0 spans the precharge window, bit 1 the signal sample.
  always_ff @(posedge clk or posedge reset)
    if (reset)
    begin
      led0    <= 1'b0;
      monitor <= '0;
    end
    else
    begin
      led0       <= in_signal || (status.phase == az_pkg::PROTECT);
      monitor[0] <= (status.phase == az_pkg::PRECHARGE) || in_signal ||
                    (status.phase == az_pkg::PROTECT);
      monitor[1] <= in_signal;
      monitor[4:2] <= status.phase;
      // low three pin bits, the mux select.
      monitor[7:5] <= azmux.raw[2:0];
    end

  // sample windows are at least one clock, so events never touch.
  a_done_is_pulse: assert property (
    @(posedge clk) disable iff (reset)
    sample_done |=> !sample_done
  );

endmodule

/* rtl/az_modulator_top.sv */
//////////////////////////////
// autozero modulator top level.
//////////////////////////////

`timescale 1ns/1ns

module az_modulator_top #(
  parameter int CLK_FREQ = 20000000
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               run,
  input  logic               load,
  input  az_pkg::az_timing_t timing_in,
  output logic               sw_pc_ctl,
  output az_pkg::az_mux_u    azmux,
  output logic               sample_done,
  output az_pkg::az_sample_t sample,
  output logic               led0,
  output logic [7:0]         monitor
);

  // 500 us of precharge and one power line cycle per sample.
  localparam logic [az_pkg::AZ_COUNT_W-1:0] PRECHARGE_N = az_pkg::AZ_COUNT_W'(CLK_FREQ / 2000);
  localparam logic [az_pkg::AZ_COUNT_W-1:0] SAMPLE_N    = az_pkg::AZ_COUNT_W'(CLK_FREQ / 50);

  az_pkg::az_timing_t timing;
  az_pkg::az_status_t status;
  logic               cycle_start;

  // input side.
  az_timing_regs #(
    .PRECHARGE_N_RESET (PRECHARGE_N),
    .SAMPLE_N_RESET    (SAMPLE_N)
  ) az_timing_regs_i (
    .clk         (clk),
    .reset       (reset),
    .load        (load),
    .timing_in   (timing_in),
    .cycle_start (cycle_start),
    .timing      (timing)
  );

  // phase FSM.
  az_sequencer az_sequencer_i (
    .clk         (clk),
    .reset       (reset),
    .run         (run),
    .timing      (timing),
    .cycle_start (cycle_start),
    .status      (status),
    .sw_pc_ctl   (sw_pc_ctl),
    .azmux       (azmux)
  );

  // output side.
  az_sample_marker az_sample_marker_i (
    .clk         (clk),
    .reset       (reset),
    .status      (status),
    .azmux       (azmux),
    .sample_done (sample_done),
    .sample      (sample),
    .led0        (led0),
    .monitor     (monitor)
  );

endmodule

/* tb/az_checks.svh */
//////////////////////////////
// compare tasks and error counters.
//////////////////////////////

`ifndef AZ_CHECKS_SVH
`define AZ_CHECKS_SVH

  // totals for the closing line.
  int error_count = 0;
  int checks_done = 0;

  // sample event, kind and cycle index together.
  task automatic check_sample(input string what, input az_pkg::az_sample_t got,
                              input az_pkg::az_sample_t exp);
    checks_done = checks_done + 1;
    if (got !== exp)
    begin
      error_count = error_count + 1;
      $display("** Error at %0t ns: %s kind %0b index %0d, expected kind %0b index %0d",
               $time, what, got.kind, got.cycle_index, exp.kind, exp.cycle_index);
    end
  endtask

  // az mux word, compared as pin levels.
  task automatic check_mux(input string what, input az_pkg::az_mux_u got,
                           input az_pkg::az_mux_u exp);
    checks_done = checks_done + 1;
    if (got.raw !== exp.raw)
    begin
      error_count = error_count + 1;
      $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got.raw, exp.raw);
    end
  endtask

  // clocks between events.
  task automatic check_count(input string what, input int got, input int exp);
    checks_done = checks_done + 1;
    if (got != exp)
    begin
      error_count = error_count + 1;
      $display("** Error at %0t ns: %s is %0d clocks, expected %0d", $time, what, got, exp);
    end
  endtask

  // single levels and the monitor byte.
  task automatic check_level(input string what, input logic [7:0] got,
                             input logic [7:0] exp);
    checks_done = checks_done + 1;
    if (got !== exp)
    begin
      error_count = error_count + 1;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

`endif

/* tb/az_modulator_tb.sv */
//////////////////////////////
// testbench for the autozero modulator.
// stimulus table, reference model, watchdog and summary.
//////////////////////////////

`timescale 1ns/1ns

module az_modulator_tb;

  localparam int NUM_ROWS    = 6;
  localparam int CLK_PERIOD  = 100;
  localparam int IDLE_CLOCKS = 20;

  // one stimulus row.
  typedef struct packed {
    az_pkg::az_timing_t timing_in;
    logic [7:0]         run_cycles;
    logic               park_after;
  } row_t;

  logic                          clk;
  logic                          reset;
  logic                          run;
  logic                          load;
  az_pkg::az_timing_t            timing_in;
  logic                          sw_pc_ctl;
  az_pkg::az_mux_u               azmux;
  logic                          sample_done;
  az_pkg::az_sample_t            sample;
  logic                          led0;
  logic [7:0]                    monitor;

  row_t                          rows [NUM_ROWS];
  logic                          rows_ready;
  integer                        seed;
  // values driven on the next rising edge.
  logic                          drv_run;
  logic                          drv_load;
  az_pkg::az_timing_t            drv_timing;
  // falling edge count and the outputs of the last two clocks.
  int                            clk_count;
  logic                          cur_sw;
  logic                          last_sw;
  az_pkg::az_mux_u               cur_mux;
  az_pkg::az_mux_u               last_mux;
  // reference model, cycle index of the next sample.
  logic [az_pkg::AZ_INDEX_W-1:0] exp_index;

  `include "az_checks.svh"

  az_modulator_top az_modulator_top_i (
    .clk         (clk),
    .reset       (reset),
    .run         (run),
    .load        (load),
    .timing_in   (timing_in),
    .sw_pc_ctl   (sw_pc_ctl),
    .azmux       (azmux),
    .sample_done (sample_done),
    .sample      (sample),
    .led0        (led0),
    .monitor     (monitor)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////
  // reference rules
  //////////////////////////////

  // a loaded zero runs as one clock.
  function automatic int effective_len(input logic [az_pkg::AZ_COUNT_W-1:0] n);
    effective_len = (n == '0) ? 1 : int'(n);
  endfunction

  // spacing of consecutive sample events.
  function automatic int period_of(input az_pkg::az_timing_t t);
    period_of = effective_len(t.precharge_n) + effective_len(t.sample_n);
  endfunction

  function automatic row_t make_row(input int pc, input int sn, input az_pkg::az_mux_u lo,
                                    input int cycles, input logic park);
    row_t row;
    row.timing_in.precharge_n = az_pkg::AZ_COUNT_W'(pc);
    row.timing_in.sample_n    = az_pkg::AZ_COUNT_W'(sn);
    row.timing_in.lo_val      = lo;
    row.run_cycles            = 8'(cycles);
    row.park_after            = park;
    return row;
  endfunction

  // short lengths with pc plus sn of at least 3, low input sel 1 to 7.
  function automatic row_t random_row(input int cycles, input logic park);
    az_pkg::az_mux_u lo;
    int              pc;
    int              sn;
    pc           = 1 + ($random(seed) & 7);
    sn           = 2 + ($random(seed) & 15);
    lo.fields.en  = 1'b1;
    lo.fields.sel = 3'(1 + (($random(seed) & 15) % 7));
    return make_row(pc, sn, lo, cycles, park);
  endfunction

  //////////////////////////////
  // drive and observe
  //////////////////////////////

  // drive on the rising edge, sample on the falling edge.
  task automatic step();
    @(posedge clk);
    run       <= drv_run;
    load      <= drv_load;
    timing_in <= drv_timing;
    @(negedge clk);
    clk_count = clk_count + 1;
    last_sw   = cur_sw;
    last_mux  = cur_mux;
    cur_sw    = sw_pc_ctl;
    cur_mux   = azmux;
  endtask

  // load is a one clock strobe.
  task automatic wait_pulse(input int limit, output int at, output logic seen);
    int start;
    start = clk_count;
    seen  = 1'b0;
    while (!seen && (clk_count - start < limit))
    begin
      step();
      drv_load = 1'b0;
      seen     = sample_done;
    end
    at = clk_count;
  endtask

  task automatic expect_no_pulse(input string where);
    if (sample_done)
    begin
      error_count = error_count + 1;
      $display("sample_done pulsed %s at %0t ns", where, $time);
    end
  endtask

  // switch levels are those of the last clock of the sample window.
  task automatic check_pulse(input logic kind, input logic seen, input int gap,
                             input int gap_exp, input az_pkg::az_mux_u lo);
    az_pkg::az_sample_t exp_s;
    if (!seen)
    begin
      error_count = error_count + 1;
      $display("no %s sample_done arrived in its window, at %0t ns",
               kind ? "signal" : "zero", $time);
    end
    else
    begin
      exp_s.kind        = kind;
      exp_s.cycle_index = exp_index;
      check_sample("sample", sample, exp_s);
      check_count("pulse interval", gap, gap_exp);
      if (kind)
      begin
        check_level("sw_pc_ctl at signal end", 8'(last_sw), 8'(az_pkg::SW_PC_SIGNAL));
        check_mux("azmux at signal end", last_mux, az_pkg::AZ_MUX_PC_OUT);
        // led and monitor lag the phase by one clock.
        check_level("led0 at signal end", 8'(led0), 8'h01);
        check_level("monitor at signal end", monitor,
                    {3'b000, 3'(az_pkg::SIGNAL), 2'b11});
      end
      else
      begin
        check_level("sw_pc_ctl at zero end", 8'(last_sw), 8'(az_pkg::SW_PC_BOOT));
        check_mux("azmux at zero end", last_mux, lo);
        // low input select shows in the top bits.
        check_level("led0 at zero end", 8'(led0), 8'h00);
        check_level("monitor at zero end", monitor,
                    {lo.fields.sel, 3'(az_pkg::ZERO), 2'b00});
      end
    end
    // the zero sample closes a cycle.
    if (!kind)
      exp_index = exp_index + 16'd1;
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial
  begin : main
    int                 pc;
    int                 sn;
    int                 at;
    int                 ref_at;
    int                 errors_before;
    logic               seen;
    logic               restart;
    az_pkg::az_timing_t t;

    seed       = 32'hd813;
    reset      = 1'b1;
    run        = 1'b0;
    load       = 1'b0;
    timing_in  = '0;
    drv_run    = 1'b0;
    drv_load   = 1'b0;
    drv_timing = '0;
    clk_count  = 0;
    cur_sw     = az_pkg::SW_PC_BOOT;
    cur_mux    = az_pkg::AZ_MUX_OFF;
    exp_index  = '0;
    ref_at     = 0;

    // zero counts in rows 2 and 4, parks after rows 2, 4 and 5.
    rows[0]    = make_row(3, 5, 4'b1001, 3, 1'b0);
    rows[1]    = random_row(2, 1'b0);
    rows[2]    = make_row(0, 2, 4'b1111, 3, 1'b1);
    rows[3]    = random_row(2, 1'b0);
    rows[4]    = make_row(6, 0, 4'b1100, 2, 1'b1);
    rows[5]    = random_row(3, 1'b1);
    rows_ready = 1'b1;

    repeat (10) @(posedge clk);
    reset <= 1'b0;

    // nothing moves before run.
    errors_before = error_count;
    repeat (IDLE_CLOCKS)
    begin
      step();
      expect_no_pulse("before run");
    end
    check_level("sw_pc_ctl idle", 8'(sw_pc_ctl), 8'(az_pkg::SW_PC_BOOT));
    check_mux("azmux idle", azmux, az_pkg::AZ_MUX_OFF);
    check_level("led0 idle", 8'(led0), 8'h00);
    check_level("monitor idle", monitor, 8'h00);
    check_sample("sample idle", sample, '0);
    $display("test 0: inactive after reset, %0d errors", error_count - errors_before);

    // first setting goes in before run.
    drv_load   = 1'b1;
    drv_timing = rows[0].timing_in;
    step();
    drv_load   = 1'b0;
    restart    = 1'b1;

    for (int r = 0; r < NUM_ROWS; r++)
    begin
      errors_before = error_count;
      t  = rows[r].timing_in;
      pc = effective_len(t.precharge_n);
      sn = effective_len(t.sample_n);
      if (restart)
      begin
        drv_run = 1'b1;
        step();
        ref_at = clk_count;
      end
      for (int c = 0; c < int'(rows[r].run_cycles); c++)
      begin
        // after run rises, boot comes first and adds one clock of latency.
        wait_pulse(2 * pc + sn + 8, at, seen);
        check_pulse(1'b1, seen, at - ref_at, (restart && c == 0) ? 1 + 2 * pc + sn : pc + sn,
                    t.lo_val);
        ref_at = at;
        if (c == int'(rows[r].run_cycles) - 1)
        begin
          // next setting lands mid cycle, run drops before zero ends.
          if (r < NUM_ROWS - 1)
          begin
            drv_load   = 1'b1;
            drv_timing = rows[r + 1].timing_in;
          end
          if (rows[r].park_after)
            drv_run = 1'b0;
        end
        wait_pulse(pc + sn + 8, at, seen);
        check_pulse(1'b0, seen, at - ref_at, pc + sn, t.lo_val);
        ref_at = at;
      end
      if (rows[r].park_after)
      begin
        check_level("sw_pc_ctl in park", 8'(cur_sw), 8'(az_pkg::SW_PC_BOOT));
        check_mux("azmux in park", cur_mux, az_pkg::AZ_MUX_OFF);
        repeat (pc + sn + 4)
        begin
          step();
          expect_no_pulse("while parked");
        end
        check_level("monitor in park", monitor, {3'b000, 3'(az_pkg::PARK), 2'b00});
        check_level("led0 in park", 8'(led0), 8'h00);
        check_mux("azmux still parked", azmux, az_pkg::AZ_MUX_OFF);
      end
      restart = rows[r].park_after;
      $display("test %0d: precharge_n %0d sample_n %0d cycles %0d park %0b, %0d errors",
               r + 1, pc, sn, rows[r].run_cycles, rows[r].park_after,
               error_count - errors_before);
    end

    $display("%0d tests, %0d checks, %0d errors", NUM_ROWS + 1, checks_done, error_count);
    if (error_count == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  //////////////////////////////
  // watchdog
  //////////////////////////////

  initial
  begin : watchdog
    int limit;
    wait (rows_ready);
    limit = 200 + 10 + IDLE_CLOCKS;
    for (int r = 0; r < NUM_ROWS; r++)
      limit = limit + (int'(rows[r].run_cycles) + 2) * 2 * period_of(rows[r].timing_in);
    #(limit * CLK_PERIOD);
    $display("timeout, the run did not end within %0d clocks", limit);
    $display("Finished with errors");
    $finish;
  end

endmodule

/* az_modulator.f */
+incdir+tb
rtl/az_pkg.sv
rtl/az_timing_regs.sv
rtl/az_sequencer.sv
rtl/az_sample_marker.sv
rtl/az_modulator_top.sv
tb/az_modulator_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the az_modulator testbench with Verilator and runs it.
# exits nonzero unless the run prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f az_modulator.f --top-module az_modulator_tb -o az_modulator_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/az_modulator_sim 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -qx "Finished with no errors"; then
  exit 0
fi
echo "pass message not found in the simulation output"
exit 1
